/* tb.f */
+incdir+.
tankDraw_pkg.sv
mapRom.sv
tankMotion.sv
tileLookupStage.sv
colourStage.sv
tankDrawTop.sv
clockGen.sv
tankDraw_properties.sv
tb_tankDraw.sv

/* run.sh */
#!/bin/bash
# Build with Verilator, run, and look for the pass line in the output
verilator --binary --timing --assert -f tb.f --top-module tb_tankDraw -o simTankDraw \
    || exit 1
./obj_dir/simTankDraw +verilator+error+limit+1000 | tee /dev/stderr \
    | grep -qx "PASS: all tests" && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation failed"; exit 1; }

/* tb_tankDraw.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_tankDraw
    import tankDraw_pkg::*;
;

    logic Master_Clock_In;
    logic reset;
    logic dispEna;
    coordT valRow;
    coordT valCol;
    logic keyUp;
    logic keyDown;
    logic keyLeft;
    logic keyRight;
    rgbT pixelRgb;

    // Reference state
    int modelX;
    int modelY;
    int pushCount;
    int assertFails;
    int testFails;
    int testsRun;
    int failsAtStart;
    integer seed;

    // Expected colour pipeline that the bound assertions read
    logic [11:0] expNow;
    logic [11:0] expPipe1;
    logic [11:0] expPipe2;
    logic checkNow;
    logic expValid1;
    logic expValid2;

    // Reference copy of the tile map with column 0 in the top nibble
    localparam logic [79:0] RefMap [15] = '{
        80'h0000_0000_0000_0000_0000,
        80'h0232_3223_2332_3223_2320,
        80'h0332_3333_2332_3333_2330,
        80'h0222_2223_2332_3222_2220,
        80'h0332_3333_2332_3333_2330,
        80'h0232_3223_2222_3223_2330,
        80'h0333_3333_3333_3333_3330,
        80'h0222_2232_2222_2322_2220,
        80'h0333_3333_3333_3333_3330,
        80'h0232_3223_2222_3223_2320,
        80'h0332_3333_2332_3333_2330,
        80'h0222_2223_2332_3222_2220,
        80'h0332_3333_2332_3333_2330,
        80'h0232_3223_2332_3223_2320,
        80'h0000_0000_0000_0000_0000
    };

    clockGen i_clockGen (
        .Master_Clock_In (Master_Clock_In),
        .reset           (reset)
    );

    tankDrawTop i_dut (
        .Master_Clock_In (Master_Clock_In),
        .reset           (reset),
        .dispEna         (dispEna),
        .valRow          (valRow),
        .valCol          (valCol),
        .keyUp           (keyUp),
        .keyDown         (keyDown),
        .keyLeft         (keyLeft),
        .keyRight        (keyRight),
        .pixelRgb        (pixelRgb)
    );

    bind tankDrawTop tankDraw_properties i_properties (
        .Master_Clock_In (Master_Clock_In),
        .reset           (reset),
        .dispEna         (dispEna),
        .pixelRgb        (pixelRgb)
    );

    ////////////////////
    // Reference model
    ////////////////////

    // Tile code of a point with indices folded back past the map edge
    function automatic int codeAt(input int x, input int y);
        int col;
        int row;
        logic [79:0] rowBits;
        col = (x >> 5) & 31;
        row = (y >> 5) & 15;
        if (col >= 20)
            col = col - 20;
        if (row >= 15)
            row = row - 15;
        rowBits = RefMap[row];
        return int'(rowBits[(19 - col) * 4 +: 4]);
    endfunction

    function automatic bit solidAt(input int x, input int y);
        int code;
        code = codeAt(x & 1023, y & 1023);
        return (code == 1) || (code == 2);
    endfunction

    function automatic logic [11:0] colourOf(input bit ena, input int x, input int y);
        int code;
        code = codeAt(x, y);
        if (!ena)
            return 12'h000;
        if ((y > 480) || (x > 640))
            return 12'h222;
        if ((x >= modelX) && (x <= modelX + 25) && (y >= modelY) && (y <= modelY + 25))
            return 12'h0A0;
        if (code == 0)
            return 12'h00F;
        if ((code == 1) || (code == 2))
            return 12'hA42;
        if (code == 3)
            return 12'hFF0;
        if ((code >= 4) && (code <= 7))
            return 12'hF44;
        return 12'h888;
    endfunction

    // One frame of motion as wrap, corner probe, then push or key step
    task automatic stepModel();
        int x;
        int y;
        bit a;
        bit b;
        bit c;
        bit d;
        x = modelX;
        y = modelY;
        if (y == 0)
            y = 455;
        else if (y == 455)
            y = 0;
        if (x == 0)
            x = 615;
        else if (x == 615)
            x = 0;
        a = solidAt(x, y);
        b = solidAt(x + 20, y);
        c = solidAt(x, y + 20);
        d = solidAt(x + 20, y + 20);
        if (a || b || c || d)
            pushCount++;
        if (a && b)
            y = y - 1;
        else if (a && c)
            x = x + 1;
        else if (c && d)
            y = y + 1;
        else if (b && d)
            x = x - 1;
        else if (a)
        begin
            y = y - 1;
            x = x + 1;
        end
        else if (b)
        begin
            y = y - 1;
            x = x - 1;
        end
        else if (c)
        begin
            y = y + 1;
            x = x + 1;
        end
        else if (d)
        begin
            y = y + 1;
            x = x - 1;
        end
        else if (keyUp)
            y = y - 1;
        else if (keyRight)
            x = x + 1;
        else if (keyDown)
            y = y + 1;
        else if (keyLeft)
            x = x - 1;
        modelX = x & 1023;
        modelY = y & 1023;
    endtask

    ////////////////////
    // Stimulus
    ////////////////////

    // Drive one pixel on the falling edge and shift the expected colours
    task automatic drivePixel(input bit ena, input int xIn, input int yIn);
        int x;
        int y;
        x = xIn & 1023;
        y = yIn & 1023;
        @(negedge Master_Clock_In);
        expPipe2 = expPipe1;
        expValid2 = expValid1;
        expPipe1 = expNow;
        expValid1 = checkNow && !reset;
        dispEna = ena;
        valRow = coordT'(x);
        valCol = coordT'(y);
        expNow = colourOf(ena, x, y);
        checkNow = 1'b1;
        // The strobe pixel still sees the old position
        if (ena && (x == 640) && (y == 480))
            stepModel();
    endtask

    task automatic runFrame();
        drivePixel(1'b1, 640, 480);
    endtask

    // Pixels on and just past the edges of the tank box
    task automatic probeBox();
        drivePixel(1'b1, modelX, modelY);
        // Far corner at the far wrap position is the strobe pixel, so use mid sides
        drivePixel(1'b1, modelX + 25, modelY + 12);
        drivePixel(1'b1, modelX + 12, modelY + 25);
        drivePixel(1'b1, modelX + 26, modelY);
        drivePixel(1'b1, modelX, modelY + 26);
        drivePixel(1'b1, modelX - 1, modelY + 12);
        drivePixel(1'b1, modelX + 12, modelY - 1);
        drivePixel(1'b1, modelX + 12, modelY + 12);
    endtask

    task automatic reportTimeout(input string what);
        $display("Timeout while waiting for %s", what);
        $display("FAIL: see errors above");
        $finish;
    endtask

    task automatic startTest();
        failsAtStart = assertFails;
    endtask

    // Flush the pipeline so late assertion failures count for this test
    task automatic endTest(input string name);
        repeat (4) drivePixel(1'b0, 0, 0);
        testsRun++;
        if (assertFails == failsAtStart)
            $display("Test %s: ok", name);
        else
        begin
            testFails++;
            $display("Test %s: failed with %0d assertion failures", name,
                     assertFails - failsAtStart);
        end
    endtask

    ////////////////////
    // Test sequence
    ////////////////////

    initial
    begin
        int n;
        int r;
        int startPush;
        dispEna = 1'b0;
        valRow = '0;
        valCol = '0;
        keyUp = 1'b0;
        keyDown = 1'b0;
        keyLeft = 1'b0;
        keyRight = 1'b0;
        modelX = 0;
        modelY = 0;
        pushCount = 0;
        assertFails = 0;
        testFails = 0;
        testsRun = 0;
        seed = 55121;
        expNow = '0;
        expPipe1 = '0;
        expPipe2 = '0;
        checkNow = 1'b0;
        expValid1 = 1'b0;
        expValid2 = 1'b0;

        // First falling edge comes after reset is asserted
        n = 0;
        do
        begin
            drivePixel(1'b0, 0, 0);
            n++;
            if (n > 40)
                reportTimeout("reset release");
        end
        while (reset);

        // Blanking covers the strobe position with enable low too
        startTest();
        drivePixel(1'b0, 640, 480);
        for (int i = 0; i < 40; i++)
        begin
            r = $random(seed);
            drivePixel(1'b0, r & 1023, (r >> 10) & 1023);
        end
        endTest("blanking");

        startTest();
        for (int i = 0; i < 30; i++)
        begin
            r = $random(seed);
            drivePixel(1'b1, 641 + ((r & 32'h7fff) % 383), (r >> 16) & 511);
            drivePixel(1'b1, (r >> 16) & 511, 481 + ((r & 32'h7fff) % 543));
        end
        endTest("range");

        startTest();
        for (int i = 0; i < 200; i++)
        begin
            r = $random(seed);
            drivePixel(1'b1, (r & 32'hffff) % 640, ((r >> 16) & 32'hffff) % 480);
        end
        endTest("map colours");

        // Odd number of frames leaves the tank at the far corner
        startTest();
        for (int i = 0; i < 5; i++)
        begin
            runFrame();
            probeBox();
        end
        endTest("wraparound");

        startTest();
        keyRight = 1'b1;
        n = 0;
        while (modelX != 12)
        begin
            runFrame();
            probeBox();
            n++;
            if (n > 40)
                reportTimeout("the tank to reach x of 12");
        end
        keyRight = 1'b0;
        keyDown = 1'b1;
        startPush = pushCount;
        n = 0;
        while (pushCount == startPush)
        begin
            runFrame();
            probeBox();
            n++;
            if (n > 60)
                reportTimeout("the tank to meet a brick tile");
        end
        repeat (4)
        begin
            runFrame();
            probeBox();
        end
        keyDown = 1'b0;
        keyLeft = 1'b1;
        repeat (3)
        begin
            runFrame();
            probeBox();
        end
        keyLeft = 1'b0;
        keyUp = 1'b1;
        repeat (3)
        begin
            runFrame();
            probeBox();
        end
        keyUp = 1'b0;
        endTest("keys and push-out");

        $display("Tests run %0d, failed %0d, assertion failures %0d",
                 testsRun, testFails, assertFails);
        if ((testFails == 0) && (assertFails == 0))
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

/* tankDraw_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module tankDraw_properties
    import tankDraw_pkg::*;
(
    input logic Master_Clock_In,
    input logic reset,
    input logic dispEna,
    input rgbT pixelRgb
);

    ////////////////////
    // Pixel colour
    ////////////////////

    // Expected colour is already delayed by two pixels in the testbench
    a_colourMatch: assert property (
        @(posedge Master_Clock_In) disable iff (reset)
        tb_tankDraw.expValid2 |-> (pixelRgb == tb_tankDraw.expPipe2)
    )
    else
    begin
        tb_tankDraw.assertFails++;
        $error("** Error pixelRgb got 0x%h expected 0x%h", pixelRgb, tb_tankDraw.expPipe2);
    end

    ////////////////////
    // Reset and blanking
    ////////////////////

    // Output register clears on reset
    a_resetClear: assert property (
        @(posedge Master_Clock_In)
        reset |=> (pixelRgb == '0)
    )
    else
    begin
        tb_tankDraw.assertFails++;
        $error("** Error pixelRgb got 0x%h expected 0x000 after reset", pixelRgb);
    end

    // Display enable low two pixels back means black now
    a_blanking: assert property (
        @(posedge Master_Clock_In) disable iff (reset)
        !$past(dispEna, 2) |-> (pixelRgb == '0)
    )
    else
    begin
        tb_tankDraw.assertFails++;
        $error("** Error pixelRgb got 0x%h expected 0x000 while blanked", pixelRgb);
    end

endmodule

`default_nettype wire

/* clockGen.sv */
`timescale 1ns/1ps
`default_nettype none

module clockGen
(
    output logic Master_Clock_In,
    output logic reset
);

    // 20 ns period
    initial
    begin
        Master_Clock_In = 1'b0;
        forever
            #10 Master_Clock_In = ~Master_Clock_In;
    end

    // Reset held for 10 cycles, released away from the rising edge
    initial
    begin
        reset = 1'b1;
        repeat (10) @(posedge Master_Clock_In);
        @(negedge Master_Clock_In);
        reset = 1'b0;
    end

endmodule

`default_nettype wire

/* tankDrawTop.sv */
`timescale 1ns/1ps
`default_nettype none

module tankDrawTop
    import tankDraw_pkg::*;
(
    input logic Master_Clock_In,
    input logic reset,
    input logic dispEna,
    input coordT valRow,
    input coordT valCol,
    input logic keyUp,
    input logic keyDown,
    input logic keyLeft,
    input logic keyRight,
    output rgbT pixelRgb
);

    pixelT pixel;
    tankPosT tankPos;
    stageOneT stageOne;

    // Row input is x, column input is y
    assign pixel = '{x: valRow, y: valCol, ena: dispEna};

    ////////////////////
    // Motion, once per frame
    ////////////////////

    tankMotion i_tankMotion (
        .Master_Clock_In (Master_Clock_In),
        .reset           (reset),
        .pixel           (pixel),
        .keyUp           (keyUp),
        .keyDown         (keyDown),
        .keyLeft         (keyLeft),
        .keyRight        (keyRight),
        .tankPos         (tankPos)
    );

    ////////////////////
    // Pixel pipeline
    ////////////////////

    // Stage 1, tile code and area flags
    tileLookupStage i_tileLookupStage (
        .Master_Clock_In (Master_Clock_In),
        .reset           (reset),
        .pixel           (pixel),
        .tankPos         (tankPos),
        .stageOne        (stageOne)
    );

    // Stage 2, final colour
    colourStage i_colourStage (
        .Master_Clock_In (Master_Clock_In),
        .reset           (reset),
        .stageOne        (stageOne),
        .pixelRgb        (pixelRgb)
    );

endmodule

`default_nettype wire

/* colourStage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tankDraw_cfg.svh"

module colourStage
    import tankDraw_pkg::*;
(
    input logic Master_Clock_In,
    input logic reset,
    input stageOneT stageOne,
    output rgbT pixelRgb
);

    rgbT nextRgb;

    ////////////////////
    // Colour priority
    ////////////////////

    always_comb
    begin
        // Blanking first, then range, then tank, then map
        if (!stageOne.ena)
            nextRgb = `ColourBlank;
        else if (!stageOne.inRange)
            nextRgb = `ColourOutOfRange;
        else if (stageOne.inTank)
            nextRgb = `ColourTank;
        else
        begin
            case (stageOne.code) inside
                // Open ground
                4'd0: nextRgb = `ColourEmpty;
                // Both solid codes draw as brick
                [4'd1:4'd2]: nextRgb = `ColourBrick;
                4'd3: nextRgb = `ColourYellow;
                [4'd4:4'd7]: nextRgb = `ColourHazard;
                // unused codes show up grey
                default: nextRgb = `ColourDefault;
            endcase
        end
    end

    // Output register
    always_ff @(posedge Master_Clock_In)
    begin
        if (reset)
            pixelRgb <= '0;
        else
            pixelRgb <= nextRgb;
    end

endmodule

`default_nettype wire

/* tileLookupStage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tankDraw_cfg.svh"

module tileLookupStage
    import tankDraw_pkg::*;
(
    input logic Master_Clock_In,
    input logic reset,
    input pixelT pixel,
    input tankPosT tankPos,
    output stageOneT stageOne
);

    // One spare bit keeps the box edge from wrapping near the top of the range
    localparam int ExtWidth = `CoordWidth + 1;

    logic [ExtWidth-1:0] boxRight;
    logic [ExtWidth-1:0] boxBottom;
    logic inRange;
    logic inTank;
    tileIndexT pixelIndex [1];
    tileCodeT pixelCode [1];

    ////////////////////
    // Tile of the pixel
    ////////////////////

    assign pixelIndex[0] = toTileIndex(pixel.x, pixel.y);

    mapRom #(
        .NumPorts (1)
    ) i_pixelRom (
        .tileIndex (pixelIndex),
        .tileCode  (pixelCode)
    );

    ////////////////////
    // Area flags
    ////////////////////

    // Limits are inclusive, so the strobe pixel itself is still in range
    assign inRange = (pixel.y <= coordT'(`PixelsVert)) && (pixel.x <= coordT'(`PixelsHoriz));

    assign boxRight = {1'b0, tankPos.x} + ExtWidth'(`TankWidth);
    assign boxBottom = {1'b0, tankPos.y} + ExtWidth'(`TankWidth);

    // Closed box from the tank corner to corner plus tank width
    assign inTank = (pixel.x >= tankPos.x)
                    && ({1'b0, pixel.x} <= boxRight)
                    && (pixel.y >= tankPos.y)
                    && ({1'b0, pixel.y} <= boxBottom);

    // Stage one register
    always_ff @(posedge Master_Clock_In)
    begin
        if (reset)
        begin
            stageOne <= '0;
        end
        else
        begin
            stageOne.ena <= pixel.ena;
            stageOne.inRange <= inRange;
            stageOne.inTank <= inTank;
            stageOne.code <= pixelCode[0];
        end
    end

endmodule

`default_nettype wire

/* tankMotion.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tankDraw_cfg.svh"

module tankMotion
    import tankDraw_pkg::*;
(
    input logic Master_Clock_In,
    input logic reset,
    input pixelT pixel,
    input logic keyUp,
    input logic keyDown,
    input logic keyLeft,
    input logic keyRight,
    output tankPosT tankPos
);

    // Corner order on the probe ports
    localparam int CornerA = 0;
    localparam int CornerB = 1;
    localparam int CornerC = 2;
    localparam int CornerD = 3;

    localparam coordT One = coordT'(1);
    localparam coordT EdgeCoord = coordT'(`EdgeWidth);
    localparam coordT ProbeStep = coordT'(`ProbeOffset);

    // Far side targets of the wrap, and the coordinates that trigger it
    localparam coordT FarX = coordT'(`PixelsHoriz - `TankWidth);
    localparam coordT FarY = coordT'(`PixelsVert - `TankWidth);
    localparam coordT LimitX = coordT'(`PixelsHoriz - `TankWidth - `EdgeWidth);
    localparam coordT LimitY = coordT'(`PixelsVert - `TankWidth - `EdgeWidth);

    logic frameStrobe;
    tankPosT wrapPos;
    tankPosT nextPos;
    coordT farX;
    coordT farY;
    tileIndexT probeIndex [4];
    tileCodeT probeCode [4];
    logic [3:0] solid;

    // One pixel past the visible corner marks the end of a frame
    assign frameStrobe = pixel.ena
                         && (pixel.x == coordT'(`PixelsHoriz))
                         && (pixel.y == coordT'(`PixelsVert));

    ////////////////////
    // Wraparound
    ////////////////////

    always_comb
    begin
        wrapPos = tankPos;
        // Leaving one edge lands on the opposite one
        if (tankPos.y == EdgeCoord)
            wrapPos.y = FarY;
        else if (tankPos.y == LimitY)
            wrapPos.y = '0;
        if (tankPos.x == EdgeCoord)
            wrapPos.x = FarX;
        else if (tankPos.x == LimitX)
            wrapPos.x = '0;
    end

    ////////////////////
    // Corner probe
    ////////////////////

    assign farX = wrapPos.x + ProbeStep;
    assign farY = wrapPos.y + ProbeStep;

    assign probeIndex[CornerA] = toTileIndex(wrapPos.x, wrapPos.y);
    assign probeIndex[CornerB] = toTileIndex(farX, wrapPos.y);
    assign probeIndex[CornerC] = toTileIndex(wrapPos.x, farY);
    assign probeIndex[CornerD] = toTileIndex(farX, farY);

    mapRom #(
        .NumPorts (4)
    ) i_probeRom (
        .tileIndex (probeIndex),
        .tileCode  (probeCode)
    );

    // Codes 1 and 2 block the tank
    always_comb
    begin
        for (int c = 0; c < 4; c++)
            solid[c] = (probeCode[c] == tileCodeT'(1)) || (probeCode[c] == tileCodeT'(2));
    end

    ////////////////////
    // Push out, then keys
    ////////////////////

    always_comb
    begin
        nextPos = wrapPos;
        // Two corners stuck, step straight away from that side
        if (solid[CornerA] && solid[CornerB])
            nextPos.y = wrapPos.y - One;
        else if (solid[CornerA] && solid[CornerC])
            nextPos.x = wrapPos.x + One;
        else if (solid[CornerC] && solid[CornerD])
            nextPos.y = wrapPos.y + One;
        else if (solid[CornerB] && solid[CornerD])
            nextPos.x = wrapPos.x - One;
        // A single corner stuck, step diagonally away from it
        else if (solid[CornerA])
        begin
            nextPos.y = wrapPos.y - One;
            nextPos.x = wrapPos.x + One;
        end
        else if (solid[CornerB])
        begin
            nextPos.y = wrapPos.y - One;
            nextPos.x = wrapPos.x - One;
        end
        else if (solid[CornerC])
        begin
            nextPos.y = wrapPos.y + One;
            nextPos.x = wrapPos.x + One;
        end
        else if (solid[CornerD])
        begin
            nextPos.y = wrapPos.y + One;
            nextPos.x = wrapPos.x - One;
        end
        // Free to move, Up wins over Right over Down over Left
        else if (keyUp)
            nextPos.y = wrapPos.y - One;
        else if (keyRight)
            nextPos.x = wrapPos.x + One;
        else if (keyDown)
            nextPos.y = wrapPos.y + One;
        else if (keyLeft)
            nextPos.x = wrapPos.x - One;
    end

    // Position moves once per frame
    always_ff @(posedge Master_Clock_In)
    begin
        if (reset)
            tankPos <= '0;
        else if (frameStrobe)
            tankPos <= nextPos;
    end

endmodule

`default_nettype wire

/* mapRom.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tankDraw_cfg.svh"

module mapRom
    import tankDraw_pkg::*;
#(
    parameter int NumPorts = 1
)
(
    input tileIndexT tileIndex [NumPorts],
    output tileCodeT tileCode [NumPorts]
);

    localparam int RowBits = `MapCols * `TileCodeWidth;
    localparam logic [TileColWidth-1:0] ColCount = TileColWidth'(`MapCols);
    localparam logic [TileRowWidth-1:0] RowCount = TileRowWidth'(`MapRows);

    ////////////////////
    // Map contents
    ////////////////////

    // One row per entry, column 0 in the top nibble
    // Border is open ground, 2 is brick, 3 is yellow floor
    localparam logic [RowBits-1:0] MapData [`MapRows] = '{
        80'h0000_0000_0000_0000_0000,
        80'h0232_3223_2332_3223_2320,
        80'h0332_3333_2332_3333_2330,
        80'h0222_2223_2332_3222_2220,
        80'h0332_3333_2332_3333_2330,
        80'h0232_3223_2222_3223_2330,
        80'h0333_3333_3333_3333_3330,
        80'h0222_2232_2222_2322_2220,
        80'h0333_3333_3333_3333_3330,
        80'h0232_3223_2222_3223_2320,
        80'h0332_3333_2332_3333_2330,
        80'h0222_2223_2332_3222_2220,
        80'h0332_3333_2332_3333_2330,
        80'h0232_3223_2332_3223_2320,
        80'h0000_0000_0000_0000_0000
    };

    ////////////////////
    // Read ports
    ////////////////////

    for (genvar p = 0; p < NumPorts; p++)
    begin : g_port
        tileIndexT folded;
        logic [RowBits-1:0] rowBits;

        always_comb
        begin
            folded = tileIndex[p];
            // Indices past the map fold back, same as a modulo by the map size
            if (folded.col >= ColCount)
                folded.col = folded.col - ColCount;
            if (folded.row >= RowCount)
                folded.row = folded.row - RowCount;
            rowBits = MapData[folded.row];
            tileCode[p] = rowBits[(`MapCols - 1 - int'(folded.col)) * `TileCodeWidth
                                  +: `TileCodeWidth];
        end
    end

endmodule

`default_nettype wire

/* tankDraw_pkg.sv */
`default_nettype none

`include "tankDraw_cfg.svh"

package tankDraw_pkg;

    // Tile index widths follow the map size
    localparam int TileColWidth = $clog2(`MapCols);
    localparam int TileRowWidth = $clog2(`MapRows);

    typedef logic [`CoordWidth-1:0] coordT;
    typedef logic [`TileCodeWidth-1:0] tileCodeT;

    // Column and row of one map tile
    typedef struct packed {
        logic [TileColWidth-1:0] col;
        logic [TileRowWidth-1:0] row;
    } tileIndexT;

    // Top left corner of the tank box
    typedef struct packed {
        coordT x;
        coordT y;
    } tankPosT;

    // Raster position from the timing generator, x is the row input
    typedef struct packed {
        coordT x;
        coordT y;
        logic ena;
    } pixelT;

    // Pixel record after the tile lookup stage
    typedef struct packed {
        logic ena;
        logic inRange;
        logic inTank;
        tileCodeT code;
    } stageOneT;

    typedef struct packed {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } rgbT;

    // Tile that holds a point; only the low bits of the shifted row survive
    function automatic tileIndexT toTileIndex(input coordT x, input coordT y);
        coordT colFull;
        coordT rowFull;
        colFull = x >> `TileShift;
        rowFull = y >> `TileShift;
        toTileIndex.col = colFull[TileColWidth-1:0];
        toTileIndex.row = rowFull[TileRowWidth-1:0];
    endfunction

endpackage

`default_nettype wire

/* tankDraw_cfg.svh */
`ifndef TankDrawCfgSvh
`define TankDrawCfgSvh

////////////////////
// Raster geometry
////////////////////

// Visible area of the 640 by 480 mode
`define PixelsHoriz 640
`define PixelsVert 480

// Every pixel and tank coordinate uses this width
`define CoordWidth 10

////////////////////
// Tile map
////////////////////

// Shift from pixel to tile, so a tile is 32 pixels square
`define TileShift 5

// Map size in tiles
`define MapCols 20
`define MapRows 15

// Width of one tile code
`define TileCodeWidth 4

////////////////////
// Tank
////////////////////

// Side of the tank box; the box is closed so it spans one pixel more
`define TankWidth 25

// Margin kept clear at the screen limits
`define EdgeWidth 0

// Distance from the tank origin to the far corners it probes
`define ProbeOffset 20

////////////////////
// Colours, 12 bits as red, green, blue
////////////////////

`define ColourBlank 12'h000
`define ColourOutOfRange 12'h222
`define ColourEmpty 12'h00F
`define ColourBrick 12'hA42
`define ColourYellow 12'hFF0
`define ColourHazard 12'hF44
`define ColourDefault 12'h888
`define ColourTank 12'h0A0

`endif
